//--- Bender.yml
package:
  name: txn_watch

sources:
  - rtl/txn_watch_pkg.sv
  - rtl/txn_timeout_monitor.sv
  - rtl/chan_req_port.sv
  - rtl/mem_rr_arbiter.sv
  - rtl/shared_mem.sv
  - rtl/txn_watch_top.sv
  - target: test
    files:
      - test/tb_txn_watch.sv

//--- rtl/chan_req_port.sv
`timescale 1ns/1ps

module chan_req_port #(
  parameter int CREDITS = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  txn_watch_pkg::mem_req_t client_req,
  input  logic                    grant,
  input  txn_watch_pkg::mem_rsp_t rsp_in,
  output logic                    credit_ret,
  output logic                    arb_req,
  output txn_watch_pkg::mem_req_t head_req,
  output txn_watch_pkg::mem_rsp_t client_rsp
);

  localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
  localparam int CNT_W = $clog2(CREDITS + 1);

  txn_watch_pkg::mem_req_t fifo_q [CREDITS];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             outstanding_q;
  logic             credit_q;
  logic             push;
  logic             pop;
  logic             empty;

  assign push  = client_req.valid;
  assign empty = (count_q == '0);
  // head is only offered with nothing in flight.
  assign arb_req = ~empty & ~outstanding_q;
  assign pop     = grant & arb_req;

  // queue storage, no reset needed on payload.
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= client_req;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(CREDITS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(CREDITS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // one request in flight; cleared by its response.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= 1'b0;
      credit_q      <= 1'b0;
    end else begin
      credit_q <= pop;
      if (pop) begin
        outstanding_q <= 1'b1;
      end else if (rsp_in.valid) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  assign credit_ret = credit_q;

  always_comb begin
    head_req       = fifo_q[rd_ptr_q];
    head_req.valid = ~empty;
  end

  // payload is zeroed when there is no response.
  assign client_rsp = rsp_in.valid ? rsp_in : '0;

endmodule

//--- rtl/mem_rr_arbiter.sv
`timescale 1ns/1ps

module mem_rr_arbiter #(
  parameter int NUM_CH = 3
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 hold,
  input  logic [NUM_CH-1:0]                    arb_req,
  input  txn_watch_pkg::mem_req_t [NUM_CH-1:0] head_req,
  output logic [NUM_CH-1:0]                    grant,
  output txn_watch_pkg::mem_req_t              mem_req,
  output logic [((NUM_CH > 1) ? $clog2(NUM_CH) : 1)-1:0] mem_ch
);

  localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

  logic [CH_W-1:0] ptr_q;
  logic [CH_W-1:0] win;
  logic            found;
  logic            gnt_any;

  // search from the pointer, wrapping around once.
  always_comb begin
    int idx;
    win   = '0;
    found = 1'b0;
    for (int k = 0; k < NUM_CH; k++) begin
      idx = int'(ptr_q) + k;
      if (idx >= NUM_CH) begin
        idx = idx - NUM_CH;
      end
      if (!found && arb_req[idx]) begin
        found = 1'b1;
        win   = CH_W'(idx);
      end
    end
    gnt_any = found & ~hold;
  end

  always_comb begin
    grant = '0;
    if (gnt_any) begin
      grant[win] = 1'b1;
    end
    mem_req       = head_req[win];
    mem_req.valid = gnt_any;
  end

  assign mem_ch = win;

  // pointer moves just past the last winner.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (gnt_any) begin
      ptr_q <= (win == CH_W'(NUM_CH - 1)) ? '0 : win + 1'b1;
    end
  end

endmodule

//--- rtl/shared_mem.sv
`timescale 1ns/1ps

module shared_mem #(
  parameter int MEM_LATENCY = 3,
  parameter int NUM_CH      = 3
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    hold,
  input  txn_watch_pkg::mem_req_t mem_req,
  input  logic [((NUM_CH > 1) ? $clog2(NUM_CH) : 1)-1:0] mem_ch,
  output txn_watch_pkg::mem_rsp_t rsp,
  output logic [((NUM_CH > 1) ? $clog2(NUM_CH) : 1)-1:0] rsp_ch
);

  localparam int CH_W  = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
  localparam int DEPTH = 2 ** txn_watch_pkg::ADDR_W;

  logic [txn_watch_pkg::DATA_W-1:0] mem_q [DEPTH];

  logic [MEM_LATENCY-1:0]           vld_q;
  logic                             wr_q   [MEM_LATENCY];
  logic [txn_watch_pkg::DATA_W-1:0] data_q [MEM_LATENCY];
  logic [CH_W-1:0]                  ch_q   [MEM_LATENCY];

  // array comes up cleared.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int a = 0; a < DEPTH; a++) begin
        mem_q[a] <= '0;
      end
    end else if (!hold && mem_req.valid && mem_req.write) begin
      mem_q[mem_req.addr] <= mem_req.wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else if (!hold) begin
      for (int s = MEM_LATENCY - 1; s > 0; s--) begin
        vld_q[s] <= vld_q[s-1];
      end
      vld_q[0] <= mem_req.valid;
    end
  end

  // response payload; read data is taken in the grant cycle.
  always_ff @(posedge clk) begin
    if (!hold) begin
      for (int s = MEM_LATENCY - 1; s > 0; s--) begin
        wr_q[s]   <= wr_q[s-1];
        data_q[s] <= data_q[s-1];
        ch_q[s]   <= ch_q[s-1];
      end
      wr_q[0]   <= mem_req.write;
      data_q[0] <= mem_req.write ? '0 : mem_q[mem_req.addr];
      ch_q[0]   <= mem_ch;
    end
  end

  // held output is masked so a response is seen only once.
  assign rsp.valid = vld_q[MEM_LATENCY-1] & ~hold;
  assign rsp.write = wr_q[MEM_LATENCY-1];
  assign rsp.rdata = data_q[MEM_LATENCY-1];
  assign rsp_ch    = ch_q[MEM_LATENCY-1];

endmodule

//--- rtl/txn_timeout_monitor.sv
`timescale 1ns/1ps

module txn_timeout_monitor #(
  parameter int NUM_CH = 3,
  parameter int CNT_W  = 8
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [NUM_CH-1:0]                  start,
  input  logic [NUM_CH-1:0][CNT_W-1:0]       budget,
  input  logic [NUM_CH-1:0]                  done,
  input  logic                               stall,
  output txn_watch_pkg::wdog_err_t [NUM_CH-1:0] err
);

  logic [NUM_CH-1:0][CNT_W-1:0] cnt_q;
  logic [NUM_CH-1:0][CNT_W-1:0] cnt_nxt;
  logic [NUM_CH-1:0]            act_q;
  logic [NUM_CH-1:0]            act_nxt;
  logic [NUM_CH-1:0]            err_expire;
  logic [NUM_CH-1:0]            err_done;
  logic [NUM_CH-1:0]            err_active;

  txn_watch_pkg::wdog_err_t [NUM_CH-1:0] err_q;

  always_comb begin
    cnt_nxt    = cnt_q;
    act_nxt    = act_q;
    err_expire = '0;
    err_done   = '0;
    err_active = '0;
    for (int i = 0; i < NUM_CH; i++) begin
      // count down on live cycles until the response shows up.
      if (!stall && !done[i] && (cnt_q[i] != '0)) begin
        cnt_nxt[i]    = cnt_q[i] - 1'b1;
        err_expire[i] = (cnt_q[i] == CNT_W'(1));
      end
      if (done[i]) begin
        cnt_nxt[i]  = '0;
        act_nxt[i]  = 1'b0;
        err_done[i] = ~act_q[i];
      end
      // a new grant wins over a response in the same cycle.
      if (start[i]) begin
        err_active[i] = act_q[i] & ~done[i];
        cnt_nxt[i]    = budget[i];
        act_nxt[i]    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      act_q <= '0;
      err_q <= '0;
    end else begin
      cnt_q <= cnt_nxt;
      act_q <= act_nxt;
      for (int i = 0; i < NUM_CH; i++) begin
        err_q[i].expired    <= err_q[i].expired    | err_expire[i];
        err_q[i].done_err   <= err_q[i].done_err   | err_done[i];
        err_q[i].active_err <= err_q[i].active_err | err_active[i];
      end
    end
  end

  assign err = err_q;

endmodule

//--- rtl/txn_watch_pkg.sv
package txn_watch_pkg;

  // address and data widths of the shared memory.
  parameter int ADDR_W = 8;
  parameter int DATA_W = 32;

  // one client request, as queued and as sent to the memory.
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  // one memory response.
  // write echoes the request, rdata is zero for writes.
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  // sticky watchdog flags of one channel.
  typedef struct packed {
    logic expired;
    logic done_err;
    logic active_err;
  } wdog_err_t;

endpackage

//--- rtl/txn_watch_top.sv
`timescale 1ns/1ps

module txn_watch_top #(
  parameter int NUM_CH      = 3,
  parameter int CREDITS     = 2,
  parameter int MEM_LATENCY = 3,
  parameter int CNT_W       = 8
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   hold,
  input  txn_watch_pkg::mem_req_t  [NUM_CH-1:0]  client_req,
  input  logic [NUM_CH-1:0][CNT_W-1:0]           budget,
  output logic [NUM_CH-1:0]                      credit_ret,
  output txn_watch_pkg::mem_rsp_t  [NUM_CH-1:0]  client_rsp,
  output txn_watch_pkg::wdog_err_t [NUM_CH-1:0]  wdog_err
);

  localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

  logic [NUM_CH-1:0]                    arb_req;
  logic [NUM_CH-1:0]                    grant;
  logic [NUM_CH-1:0]                    rsp_done;
  txn_watch_pkg::mem_req_t [NUM_CH-1:0] head_req;
  txn_watch_pkg::mem_rsp_t [NUM_CH-1:0] port_rsp;
  txn_watch_pkg::mem_req_t              mem_req;
  txn_watch_pkg::mem_rsp_t              mem_rsp;
  logic [CH_W-1:0]                      mem_ch;
  logic [CH_W-1:0]                      rsp_ch;

  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
    // response goes only to the channel it is tagged with.
    assign port_rsp[i].valid = mem_rsp.valid && (rsp_ch == CH_W'(i));
    assign port_rsp[i].write = mem_rsp.write;
    assign port_rsp[i].rdata = mem_rsp.rdata;
    assign rsp_done[i]       = port_rsp[i].valid;

    chan_req_port #(
      .CREDITS (CREDITS)
    ) u_port (
      .clk        (clk),
      .rst_n      (rst_n),
      .client_req (client_req[i]),
      .grant      (grant[i]),
      .rsp_in     (port_rsp[i]),
      .credit_ret (credit_ret[i]),
      .arb_req    (arb_req[i]),
      .head_req   (head_req[i]),
      .client_rsp (client_rsp[i])
    );
  end

  mem_rr_arbiter #(
    .NUM_CH (NUM_CH)
  ) u_arb (
    .clk      (clk),
    .rst_n    (rst_n),
    .hold     (hold),
    .arb_req  (arb_req),
    .head_req (head_req),
    .grant    (grant),
    .mem_req  (mem_req),
    .mem_ch   (mem_ch)
  );

  shared_mem #(
    .MEM_LATENCY (MEM_LATENCY),
    .NUM_CH      (NUM_CH)
  ) u_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .hold    (hold),
    .mem_req (mem_req),
    .mem_ch  (mem_ch),
    .rsp     (mem_rsp),
    .rsp_ch  (rsp_ch)
  );

  txn_timeout_monitor #(
    .NUM_CH (NUM_CH),
    .CNT_W  (CNT_W)
  ) u_mon (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (grant),
    .budget (budget),
    .done   (rsp_done),
    .stall  (hold),
    .err    (wdog_err)
  );

endmodule

//--- test/tb_txn_watch.sv
`timescale 1ns/1ps

module tb_txn_watch;

  localparam int NUM_CH      = 3;
  localparam int CREDITS     = 2;
  localparam int MEM_LATENCY = 3;
  localparam int CNT_W       = 8;
  localparam int ADDR_W      = txn_watch_pkg::ADDR_W;
  localparam int DATA_W      = txn_watch_pkg::DATA_W;
  localparam int BUF_D       = 8;
  // 24 directed, 12 parallel, 30 random, 6 budget requests.
  localparam int NUM_REQ     = 72;
  localparam int TIMEOUT_CYC = 40 * NUM_REQ + 200;

  logic                                   clk;
  logic                                   rst_n;
  logic                                   hold;
  txn_watch_pkg::mem_req_t  [NUM_CH-1:0]  client_req;
  logic [NUM_CH-1:0][CNT_W-1:0]           budget;
  logic [NUM_CH-1:0]                      credit_ret;
  txn_watch_pkg::mem_rsp_t  [NUM_CH-1:0]  client_rsp;
  txn_watch_pkg::wdog_err_t [NUM_CH-1:0]  wdog_err;

  logic [DATA_W-1:0]         ref_array [2**ADDR_W];
  txn_watch_pkg::mem_rsp_t   exp_buf   [NUM_CH][BUF_D];
  txn_watch_pkg::wdog_err_t  exp_err   [NUM_CH];
  int                        wr_idx    [NUM_CH];
  int                        rd_idx    [NUM_CH];
  int                        sent_cnt  [NUM_CH];
  int                        ret_cnt   [NUM_CH];
  logic [31:0]               rand_state = 32'd45;
  logic                      hold_en;
  int                        cycles = 0;

  txn_watch_top #(
    .NUM_CH      (NUM_CH),
    .CREDITS     (CREDITS),
    .MEM_LATENCY (MEM_LATENCY),
    .CNT_W       (CNT_W)
  ) u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .hold       (hold),
    .client_req (client_req),
    .budget     (budget),
    .credit_ret (credit_ret),
    .client_rsp (client_rsp),
    .wdog_err   (wdog_err)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'((next_rand() >> 16) % n);
  endfunction

  // each channel owns the addresses congruent to its index mod 4.
  function automatic logic [ADDR_W-1:0] chan_addr(input int ch, input int r);
    return ADDR_W'((r % 64) * 4 + ch);
  endfunction

  // memory model, updated in per-channel issue order.
  function automatic txn_watch_pkg::mem_rsp_t ref_mem(input txn_watch_pkg::mem_req_t req);
    txn_watch_pkg::mem_rsp_t r;
    r.valid = 1'b1;
    r.write = req.write;
    r.rdata = '0;
    if (req.write) begin
      ref_array[req.addr] = req.wdata;
    end else begin
      r.rdata = ref_array[req.addr];
    end
    return r;
  endfunction

  // a nonzero budget shorter than the latency must expire.
  function automatic txn_watch_pkg::wdog_err_t ref_err(input logic [CNT_W-1:0] b);
    txn_watch_pkg::wdog_err_t e;
    e         = '0;
    e.expired = (b != '0) && (int'(b) < MEM_LATENCY);
    return e;
  endfunction

  task automatic check_rsp(input int ch, input txn_watch_pkg::mem_rsp_t got,
                           input txn_watch_pkg::mem_rsp_t exp_rsp);
    if (got !== exp_rsp) begin
      abort_run($sformatf("FAIL @%0t: ch%0d rsp got w=%0b d=%h, expected w=%0b d=%h",
                          $time, ch, got.write, got.rdata, exp_rsp.write, exp_rsp.rdata));
    end
  endtask

  task automatic check_err(input int ch, input txn_watch_pkg::wdog_err_t got,
                           input txn_watch_pkg::wdog_err_t exp_e);
    if (got !== exp_e) begin
      abort_run($sformatf("FAIL @%0t: ch%0d err got %b, expected %b",
                          $time, ch, got, exp_e));
    end
  endtask

  // one falling-edge drive; a request goes out only with a credit in hand.
  task automatic drive_cycle(input txn_watch_pkg::mem_req_t [NUM_CH-1:0] reqs,
                             output logic [NUM_CH-1:0] sent);
    txn_watch_pkg::mem_req_t [NUM_CH-1:0] drv;
    @(negedge clk);
    drv  = '0;
    sent = '0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (reqs[ch].valid && (sent_cnt[ch] - ret_cnt[ch] < CREDITS)) begin
        drv[ch]  = reqs[ch];
        sent[ch] = 1'b1;
        sent_cnt[ch]++;
        exp_buf[ch][wr_idx[ch] % BUF_D] = ref_mem(reqs[ch]);
        wr_idx[ch]++;
        exp_err[ch] = exp_err[ch] | ref_err(budget[ch]);
      end
    end
    client_req = drv;
    hold       = hold_en && (rand_below(4) == 0);
  endtask

  task automatic send_all(input txn_watch_pkg::mem_req_t [NUM_CH-1:0] reqs);
    txn_watch_pkg::mem_req_t [NUM_CH-1:0] left;
    logic [NUM_CH-1:0]                    sent;
    left = reqs;
    while (|{left[0].valid, left[1].valid, left[2].valid}) begin
      drive_cycle(left, sent);
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (sent[ch]) begin
          left[ch].valid = 1'b0;
        end
      end
    end
  endtask

  task automatic send_one(input int ch, input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data);
    txn_watch_pkg::mem_req_t [NUM_CH-1:0] reqs;
    reqs           = '0;
    reqs[ch].valid = 1'b1;
    reqs[ch].write = wr;
    reqs[ch].addr  = addr;
    reqs[ch].wdata = wr ? data : '0;
    send_all(reqs);
  endtask

  // idle until every response is back.
  task automatic drain();
    logic [NUM_CH-1:0] sent;
    logic              busy;
    busy = 1'b1;
    while (busy) begin
      drive_cycle('0, sent);
      busy = 1'b0;
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (wr_idx[ch] != rd_idx[ch]) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  task automatic check_all_err();
    for (int ch = 0; ch < NUM_CH; ch++) begin
      check_err(ch, wdog_err[ch], exp_err[ch]);
    end
  endtask

  // response and credit checker.
  always @(posedge clk) begin
    if (rst_n) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (credit_ret[ch]) begin
          if (ret_cnt[ch] >= sent_cnt[ch]) begin
            abort_run($sformatf("credit returned on channel %0d with no request queued", ch));
          end
          ret_cnt[ch]++;
        end
        if (client_rsp[ch].valid) begin
          if (rd_idx[ch] == wr_idx[ch]) begin
            abort_run($sformatf("response on channel %0d with nothing outstanding", ch));
          end
          check_rsp(ch, client_rsp[ch], exp_buf[ch][rd_idx[ch] % BUF_D]);
          rd_idx[ch]++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYC) begin
      abort_run($sformatf("timeout after %0d cycles, responses still missing", cycles));
    end
  end

  initial begin
    txn_watch_pkg::mem_req_t [NUM_CH-1:0] reqs;
    logic                                 credits_ok;
    int                                   rnd_ch;
    logic                                 rnd_wr;
    logic [ADDR_W-1:0]                    rnd_addr;
    rst_n      = 1'b0;
    hold       = 1'b0;
    hold_en    = 1'b0;
    client_req = '0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      budget[ch]   = CNT_W'(8);
      exp_err[ch]  = '0;
      wr_idx[ch]   = 0;
      rd_idx[ch]   = 0;
      sent_cnt[ch] = 0;
      ret_cnt[ch]  = 0;
    end
    for (int a = 0; a < 2**ADDR_W; a++) begin
      ref_array[a] = '0;
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // writes then reads on every channel.
    for (int ch = 0; ch < NUM_CH; ch++) begin
      for (int k = 0; k < 4; k++) begin
        send_one(ch, 1'b1, chan_addr(ch, k), next_rand());
      end
      for (int k = 0; k < 4; k++) begin
        send_one(ch, 1'b0, chan_addr(ch, k), '0);
      end
    end
    drain();
    check_all_err();

    // all channels request in the same cycle.
    repeat (4) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        reqs[ch].valid = 1'b1;
        reqs[ch].write = (rand_below(2) == 1);
        reqs[ch].addr  = chan_addr(ch, rand_below(64));
        reqs[ch].wdata = next_rand();
      end
      send_all(reqs);
    end
    drain();
    check_all_err();

    // random traffic under random hold.
    hold_en = 1'b1;
    repeat (30) begin
      rnd_ch   = rand_below(NUM_CH);
      rnd_wr   = (rand_below(2) == 1);
      rnd_addr = chan_addr(rnd_ch, rand_below(64));
      send_one(rnd_ch, rnd_wr, rnd_addr, next_rand());
    end
    drain();
    hold_en = 1'b0;
    drain();
    check_all_err();

    // short budget on ch0, disabled on ch1, generous on ch2.
    budget[0] = CNT_W'(1);
    budget[1] = CNT_W'(0);
    budget[2] = CNT_W'(200);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      send_one(ch, 1'b1, chan_addr(ch, 60), next_rand());
      send_one(ch, 1'b0, chan_addr(ch, 60), '0);
    end
    drain();
    check_all_err();

    credits_ok = 1'b1;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (sent_cnt[ch] != ret_cnt[ch]) begin
        credits_ok = 1'b0;
      end
    end
    if (!credits_ok) begin
      abort_run("credit count did not return to its initial value");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

//--- vlog.f
rtl/txn_watch_pkg.sv
rtl/txn_timeout_monitor.sv
rtl/chan_req_port.sv
rtl/mem_rr_arbiter.sv
rtl/shared_mem.sv
rtl/txn_watch_top.sv
test/tb_txn_watch.sv
